// File: rtl/nebula_bus_pkg.sv
// Wishbone classic request and response structs
// Byte-lane merge helper shared by the bus targets
package nebula_bus_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;  // 71 bits

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Keeps old bytes where sel is low
    function automatic logic [31:0] wb_merge(logic [31:0] old_w, logic [31:0] new_w,
                                             logic [3:0] sel);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: rtl/nebula_map_pkg.sv
// Address map region codes, field widths and pin constants
package nebula_map_pkg;

    // Region field sits in adr[15:12]
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = 4;

    // Word offset inside a region, adr[11:2]
    localparam int WORD_LSB = 2;
    localparam int OFFSET_W = 10;

    localparam logic [REGION_W-1:0] REGION_SRAM  = 4'd0;
    localparam logic [REGION_W-1:0] REGION_GPIO  = 4'd1;
    localparam logic [REGION_W-1:0] REGION_TEAM0 = 4'd2;  // Team t at 2+t

    localparam int NUM_PINS = 38;
    localparam int OWNER_W  = 4;   // Eight owner fields per word

endpackage

// File: rtl/wb_arbiter.sv
`timescale 1ns/1ps
// Two-manager Wishbone arbiter, round robin, grant held for the whole cycle
module wb_arbiter (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  nebula_bus_pkg::wb_req_t m_req_i [2],
    output nebula_bus_pkg::wb_rsp_t m_rsp_o [2],
    output nebula_bus_pkg::wb_req_t s_req_o,
    input  nebula_bus_pkg::wb_rsp_t s_rsp_i
);

    logic [1:0] cyc;
    logic [1:0] gnt_q;   // One-hot owner, zero when free
    logic       last_q;  // Index served most recently

    assign cyc = {m_req_i[1].cyc, m_req_i[0].cyc};

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            gnt_q  <= 2'b00;
            last_q <= 1'b1;  // mgmt wins the first tie
        end else if (gnt_q == 2'b00) begin
            if (cyc == 2'b11) begin
                gnt_q  <= last_q ? 2'b01 : 2'b10;
                last_q <= ~last_q;
            end else if (cyc[0]) begin
                gnt_q  <= 2'b01;
                last_q <= 1'b0;
            end else if (cyc[1]) begin
                gnt_q  <= 2'b10;
                last_q <= 1'b1;
            end
        end else if ((gnt_q & cyc) == 2'b00) begin
            gnt_q <= 2'b00;  // Owner dropped cyc
        end
    end

    always_comb begin
        s_req_o = '0;
        if (gnt_q[0]) begin
            s_req_o = m_req_i[0];
        end else if (gnt_q[1]) begin
            s_req_o = m_req_i[1];
        end
    end

    // Waiting manager sees ack low
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            m_rsp_o[i].ack = s_rsp_i.ack & gnt_q[i];
            m_rsp_o[i].dat = s_rsp_i.dat;
        end
    end

    a_one_owner: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0(gnt_q))
        else $error("arbiter granted both managers");

endmodule

// File: rtl/wb_decoder.sv
`timescale 1ns/1ps
// Address decoder from one manager to SRAM, GPIO and team targets
// Unmapped regions get a zero-data ack
module wb_decoder #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  nebula_bus_pkg::wb_req_t m_req_i,
    output nebula_bus_pkg::wb_rsp_t m_rsp_o,
    output nebula_bus_pkg::wb_req_t t_req_o [NUM_TEAMS+2],
    input  nebula_bus_pkg::wb_rsp_t t_rsp_i [NUM_TEAMS+2]
);
    import nebula_map_pkg::*;

    localparam int NT = NUM_TEAMS + 2;

    logic [REGION_W-1:0] region;
    logic [NT-1:0]       hit;
    logic [NT-1:0]       stb_vec;
    logic                um_ack_q;

    assign region = m_req_i.adr[REGION_LSB +: REGION_W];

    always_comb begin
        hit    = '0;
        hit[0] = (region == REGION_SRAM);
        hit[1] = (region == REGION_GPIO);
        for (int t = 0; t < NUM_TEAMS; t++) begin
            hit[2+t] = (region == REGION_W'(REGION_TEAM0 + t));
        end
    end

    // Only the addressed target sees cyc and stb
    always_comb begin
        for (int i = 0; i < NT; i++) begin
            t_req_o[i]     = m_req_i;
            t_req_o[i].cyc = m_req_i.cyc & hit[i];
            t_req_o[i].stb = m_req_i.stb & hit[i];
            stb_vec[i]     = t_req_o[i].stb;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            um_ack_q <= 1'b0;
        end else begin
            um_ack_q <= m_req_i.cyc & m_req_i.stb & ~(|hit) & ~um_ack_q;
        end
    end

    always_comb begin
        m_rsp_o.ack = um_ack_q;  // Low whenever a target is hit
        m_rsp_o.dat = '0;
        for (int i = 0; i < NT; i++) begin
            if (hit[i]) begin
                m_rsp_o = t_rsp_i[i];
            end
        end
    end

    a_one_target: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0(stb_vec))
        else $error("decoder strobed more than one target");

endmodule

// File: rtl/wb_sram.sv
`timescale 1ns/1ps
// Single-port word SRAM with byte-lane writes on a Wishbone target port
module wb_sram #(
    parameter int SRAM_WORDS = 256
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_i,
    input  nebula_bus_pkg::wb_req_t req_i,
    output nebula_bus_pkg::wb_rsp_t rsp_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    localparam int AW = $clog2(SRAM_WORDS);

    logic [31:0]         mem [SRAM_WORDS];
    logic [OFFSET_W-1:0] offset;
    logic [AW-1:0]       addr;
    logic                access;
    logic                ack_q;
    logic [31:0]         dat_q;

    assign offset = req_i.adr[WORD_LSB +: OFFSET_W];
    assign addr   = offset[AW-1:0];  // Wraps modulo SRAM_WORDS
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            if (req_i.we) begin
                mem[addr] <= wb_merge(mem[addr], req_i.dat, req_i.sel);
            end
            dat_q <= mem[addr];
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

    a_ack_pulse: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        ack_q |=> !ack_q)
        else $error("sram ack held two cycles");

endmodule

// File: rtl/gpio_control.sv
`timescale 1ns/1ps
// GPIO control registers and per-pin output mux between management and teams
module gpio_control #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                                wb_clk_i,
    input  logic                                rst_i,
    input  nebula_bus_pkg::wb_req_t             req_i,
    output nebula_bus_pkg::wb_rsp_t             rsp_o,
    input  logic [nebula_map_pkg::NUM_PINS-1:0] team_out_i [NUM_TEAMS],
    input  logic [nebula_map_pkg::NUM_PINS-1:0] team_oeb_i [NUM_TEAMS],
    output logic [nebula_map_pkg::NUM_PINS-1:0] io_out_o,
    output logic [nebula_map_pkg::NUM_PINS-1:0] io_oeb_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    localparam int OWN_WORDS = (NUM_PINS * OWNER_W + 31) / 32;

    logic [OFFSET_W-1:0]      off;
    logic                     access;
    logic                     ack_q;
    logic [31:0]              dat_q;
    logic [31:0]              rdata;
    logic [31:0]              own_q [OWN_WORDS];  // Offsets 0..4
    logic [31:0]              out_q [2];          // Offsets 8, 9
    logic [31:0]              oeb_q [2];          // Offsets 10, 11
    logic [OWN_WORDS*32-1:0]  own_flat;
    logic [OWNER_W-1:0]       owner [NUM_PINS];   // After range check

    assign off    = req_i.adr[WORD_LSB +: OFFSET_W];
    assign access = req_i.cyc & req_i.stb & ~ack_q;

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
            own_q <= '{default: '0};
            out_q <= '{default: '0};
            oeb_q <= '{default: '1};  // All pins start as inputs
        end else begin
            ack_q <= access;
            if (access && req_i.we) begin
                for (int w = 0; w < OWN_WORDS; w++) begin
                    if (off == OFFSET_W'(w)) begin
                        own_q[w] <= wb_merge(own_q[w], req_i.dat, req_i.sel);
                    end
                end
                for (int h = 0; h < 2; h++) begin
                    if (off == OFFSET_W'(8 + h)) begin
                        out_q[h] <= wb_merge(out_q[h], req_i.dat, req_i.sel);
                    end
                    if (off == OFFSET_W'(10 + h)) begin
                        oeb_q[h] <= wb_merge(oeb_q[h], req_i.dat, req_i.sel);
                    end
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        for (int w = 0; w < OWN_WORDS; w++) begin
            if (off == OFFSET_W'(w)) begin
                rdata = own_q[w];
            end
        end
        for (int h = 0; h < 2; h++) begin
            if (off == OFFSET_W'(8 + h)) begin
                rdata = out_q[h];
            end
            if (off == OFFSET_W'(10 + h)) begin
                rdata = oeb_q[h];
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            dat_q <= rdata;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;

    always_comb begin
        for (int w = 0; w < OWN_WORDS; w++) begin
            own_flat[w*32 +: 32] = own_q[w];
        end
        for (int p = 0; p < NUM_PINS; p++) begin
            owner[p] = own_flat[p*OWNER_W +: OWNER_W];
            if (owner[p] > OWNER_W'(NUM_TEAMS)) begin
                owner[p] = '0;  // No such team, back to management
            end
            io_out_o[p] = (p < 32) ? out_q[0][p % 32] : out_q[1][p % 32];
            io_oeb_o[p] = (p < 32) ? oeb_q[0][p % 32] : oeb_q[1][p % 32];
            for (int t = 0; t < NUM_TEAMS; t++) begin
                if (owner[p] == OWNER_W'(t + 1)) begin
                    io_out_o[p] = team_out_i[t][p];
                    io_oeb_o[p] = team_oeb_i[t][p];
                end
            end
        end
    end

    for (genvar p = 0; p < NUM_PINS; p++) begin : g_owner_chk
        a_owner_range: assert property (@(posedge wb_clk_i) disable iff (rst_i)
            (own_flat[p*OWNER_W +: OWNER_W] > OWNER_W'(NUM_TEAMS)) |->
                (io_out_o[p] == out_q[p / 32][p % 32] &&
                 io_oeb_o[p] == oeb_q[p / 32][p % 32]))
            else $error("pin %0d with a missing team is not driven by management", p);
    end

endmodule

// File: rtl/team_counter.sv
`timescale 1ns/1ps
// Sample team project, Wishbone-controlled free-running counter on pins 0..7
module team_counter (
    input  logic                                wb_clk_i,
    input  logic                                rst_i,
    input  nebula_bus_pkg::wb_req_t             req_i,
    output nebula_bus_pkg::wb_rsp_t             rsp_o,
    output logic [nebula_map_pkg::NUM_PINS-1:0] gpio_out_o,
    output logic [nebula_map_pkg::NUM_PINS-1:0] gpio_oeb_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    logic [OFFSET_W-1:0] off;
    logic                wr;
    logic                ctrl_wr;
    logic                ack_q;
    logic                en_q;
    logic [31:0]         count_q;
    logic [31:0]         scratch_q;
    logic [31:0]         dat_q;
    logic [31:0]         rdata;

    assign off     = req_i.adr[WORD_LSB +: OFFSET_W];
    assign wr      = req_i.cyc & req_i.stb & ~ack_q & req_i.we;
    assign ctrl_wr = wr & (off == '0) & req_i.sel[0];

    always_ff @(posedge wb_clk_i) begin
        if (rst_i) begin
            ack_q   <= 1'b0;
            en_q    <= 1'b0;
            count_q <= '0;
        end else begin
            ack_q <= req_i.cyc & req_i.stb & ~ack_q;
            if (ctrl_wr) begin
                en_q <= req_i.dat[0];
            end
            if (ctrl_wr && req_i.dat[1]) begin
                count_q <= '0;  // Clear bit is a pulse, never stored
            end else if (en_q) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    always_comb begin
        case (off)
            OFFSET_W'(0): rdata = {31'b0, en_q};
            OFFSET_W'(1): rdata = count_q;
            OFFSET_W'(2): rdata = scratch_q;
            default:      rdata = '0;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (wr && off == OFFSET_W'(2)) begin
            scratch_q <= wb_merge(scratch_q, req_i.dat, req_i.sel);
        end
        if (req_i.cyc && req_i.stb && !ack_q) begin
            dat_q <= rdata;
        end
    end

    assign rsp_o.ack  = ack_q;
    assign rsp_o.dat  = dat_q;
    assign gpio_out_o = {{(NUM_PINS-8){1'b0}}, count_q[7:0]};
    assign gpio_oeb_o = {{(NUM_PINS-8){1'b1}}, {8{~en_q}}};  // Drive only while counting

endmodule

// File: rtl/nebula_top.sv
`timescale 1ns/1ps
// User area top, two managers through arbiter and decoder to SRAM, GPIO and teams
module nebula_top #(
    parameter int NUM_TEAMS  = 2,
    parameter int SRAM_WORDS = 256
) (
    input  logic                                wb_clk_i,
    input  logic                                rst_i,
    input  nebula_bus_pkg::wb_req_t             mgmt_req_i,
    output nebula_bus_pkg::wb_rsp_t             mgmt_rsp_o,
    input  nebula_bus_pkg::wb_req_t             aux_req_i,
    output nebula_bus_pkg::wb_rsp_t             aux_rsp_o,
    output logic [nebula_map_pkg::NUM_PINS-1:0] io_out_o,
    output logic [nebula_map_pkg::NUM_PINS-1:0] io_oeb_o,
    output logic [2:0]                          irq_o
);
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    wb_req_t             mgr_req [2];    // 0 mgmt, 1 aux
    wb_rsp_t             mgr_rsp [2];
    wb_req_t             bus_req;
    wb_rsp_t             bus_rsp;
    wb_req_t             tgt_req [NUM_TEAMS+2];  // SRAM, GPIO, then teams
    wb_rsp_t             tgt_rsp [NUM_TEAMS+2];
    logic [NUM_PINS-1:0] team_out [NUM_TEAMS];
    logic [NUM_PINS-1:0] team_oeb [NUM_TEAMS];

    assign mgr_req[0] = mgmt_req_i;
    assign mgr_req[1] = aux_req_i;
    assign mgmt_rsp_o = mgr_rsp[0];
    assign aux_rsp_o  = mgr_rsp[1];
    assign irq_o      = 3'b000;  // No interrupt sources

    wb_arbiter u_arb (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .m_req_i(mgr_req), .m_rsp_o(mgr_rsp),
        .s_req_o(bus_req), .s_rsp_i(bus_rsp)
    );

    wb_decoder #(.NUM_TEAMS(NUM_TEAMS)) u_dec (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .m_req_i(bus_req), .m_rsp_o(bus_rsp),
        .t_req_o(tgt_req), .t_rsp_i(tgt_rsp)
    );

    wb_sram #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .req_i(tgt_req[0]), .rsp_o(tgt_rsp[0])
    );

    gpio_control #(.NUM_TEAMS(NUM_TEAMS)) u_gpio (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .req_i(tgt_req[1]), .rsp_o(tgt_rsp[1]),
        .team_out_i(team_out), .team_oeb_i(team_oeb),
        .io_out_o(io_out_o), .io_oeb_o(io_oeb_o)
    );

    for (genvar t = 0; t < NUM_TEAMS; t++) begin : g_team
        team_counter u_team (
            .wb_clk_i(wb_clk_i), .rst_i(rst_i),
            .req_i(tgt_req[2+t]), .rsp_o(tgt_rsp[2+t]),
            .gpio_out_o(team_out[t]), .gpio_oeb_o(team_oeb[t])
        );
    end

endmodule

// File: verif/nebula_tb.sv
`timescale 1ns/1ps
// Testbench for the user area top with bus tasks, SRAM and GPIO register models
// Checks reset state, SRAM byte lanes, arbitration, GPIO drive, teams and unmapped cycles
module nebula_tb;
    import nebula_bus_pkg::*;
    import nebula_map_pkg::*;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int N_WR           = 20;

    logic                wb_clk_i;
    logic                rst_i;
    wb_req_t             mgmt_req;
    wb_rsp_t             mgmt_rsp;
    wb_req_t             aux_req;
    wb_rsp_t             aux_rsp;
    logic [NUM_PINS-1:0] io_out;
    logic [NUM_PINS-1:0] io_oeb;
    logic [2:0]          irq;

    logic [31:0] sram_model [256];
    logic [31:0] own_model [5];   // Owner words, eight pins each
    logic [31:0] out_model [2];   // Pins 0..31, then 32..37
    logic [31:0] oeb_model [2];

    int err_cnt;
    int err_mark;
    int tests_ok;
    int tests_bad;

    nebula_top dut0 (
        .wb_clk_i(wb_clk_i), .rst_i(rst_i),
        .mgmt_req_i(mgmt_req), .mgmt_rsp_o(mgmt_rsp),
        .aux_req_i(aux_req), .aux_rsp_o(aux_rsp),
        .io_out_o(io_out), .io_oeb_o(io_oeb), .irq_o(irq)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #20 wb_clk_i = ~wb_clk_i;
    end

    function automatic logic [31:0] make_adr(input logic [3:0] region, input logic [9:0] word);
        return {16'h0, region, word, 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  sel);
        logic [31:0] mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    // Management pin vector from the two register halves
    function automatic logic [NUM_PINS-1:0] mgmt_pins(input logic [31:0] lo,
                                                      input logic [31:0] hi);
        return {hi[NUM_PINS-33:0], lo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("MISMATCH time %0t signal %s expected 0x%0h actual 0x%0h",
                     $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // One single-beat cycle, started and sampled on falling edges
    task automatic bus_access(input int port, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        wb_req_t req;
        logic    ack;
        int      n;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.sel = sel;
        req.adr = adr;
        req.dat = wdat;
        rdat = '0;
        ack  = 1'b0;
        n    = 0;
        if (port == 0) mgmt_req = req;
        else aux_req = req;
        while (!ack && n < TIMEOUT_CYCLES) begin
            @(negedge wb_clk_i);
            n++;
            ack  = (port == 0) ? mgmt_rsp.ack : aux_rsp.ack;
            rdat = (port == 0) ? mgmt_rsp.dat : aux_rsp.dat;
        end
        if (!ack) begin
            $display("%s port saw no ack within %0d cycles for address 0x%h at time %0t",
                     (port == 0) ? "mgmt" : "aux", TIMEOUT_CYCLES, adr, $time);
            err_cnt++;
        end
        if (port == 0) mgmt_req = '0;
        else aux_req = '0;
        @(negedge wb_clk_i);  // Idle cycle so the grant is released
    endtask

    task automatic mgmt_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        bus_access(0, we, sel, adr, wdat, rdat);
    endtask

    task automatic aux_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
        bus_access(1, we, sel, adr, wdat, rdat);
    endtask

    task automatic write_word(input logic [31:0] adr, input logic [31:0] wdat);
        logic [31:0] unused_dat;
        mgmt_access(1'b1, 4'hF, adr, wdat, unused_dat);
    endtask

    task automatic read_word(input logic [31:0] adr, output logic [31:0] rdat);
        mgmt_access(1'b0, 4'hF, adr, 32'h0, rdat);
    endtask

    task automatic end_test(input string name);
        if (err_cnt == err_mark) begin
            tests_ok++;
            $display("test %s: pass", name);
        end else begin
            tests_bad++;
            $display("test %s: fail with %0d errors", name, err_cnt - err_mark);
        end
        err_mark = err_cnt;
    endtask

    initial begin
        logic [7:0]          idx [N_WR];
        logic [31:0]         wdat;
        logic [31:0]         w_a;
        logic [31:0]         w_b;
        logic [31:0]         rdat;
        logic [31:0]         rdat2;
        logic [3:0]          sel;
        logic [NUM_PINS-1:0] pins;
        void'($urandom(77));
        rst_i     = 1'b1;
        mgmt_req  = '0;
        aux_req   = '0;
        err_cnt   = 0;
        err_mark  = 0;
        tests_ok  = 0;
        tests_bad = 0;
        repeat (5) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        rst_i = 1'b0;

        check_value("io_oeb_o", 64'({NUM_PINS{1'b1}}), 64'(io_oeb));
        check_value("io_out_o", 64'h0, 64'(io_out));
        check_value("irq_o", 64'h0, 64'(irq));
        end_test("reset state");

        // Full-word fill first so every byte of the model is known
        for (int i = 0; i < N_WR; i++) begin
            idx[i] = 8'($urandom);
            wdat   = {~idx[i], idx[i], idx[i] ^ 8'h5A, idx[i] + 8'hC3};
            write_word(make_adr(REGION_SRAM, 10'(idx[i])), wdat);
            sram_model[idx[i]] = wdat;
        end
        for (int i = 0; i < N_WR; i++) begin
            wdat = $urandom;
            sel  = 4'($urandom);
            mgmt_access(1'b1, sel, make_adr(REGION_SRAM, 10'(idx[i])), wdat, rdat);
            sram_model[idx[i]] = merge_bytes(sram_model[idx[i]], wdat, sel);
        end
        for (int i = 0; i < N_WR; i++) begin
            read_word(make_adr(REGION_SRAM, 10'(idx[i])), rdat);
            check_value("mgmt_rsp_o.dat", 64'(sram_model[idx[i]]), 64'(rdat));
        end
        end_test("sram byte selects");

        w_a = $urandom;
        w_b = $urandom;
        fork
            mgmt_access(1'b1, 4'hF, make_adr(REGION_SRAM, 10'd250), w_a, rdat);
            aux_access(1'b1, 4'hF, make_adr(REGION_SRAM, 10'd251), w_b, rdat2);
        join
        sram_model[250] = w_a;
        sram_model[251] = w_b;
        aux_access(1'b0, 4'hF, make_adr(REGION_SRAM, 10'd250), 32'h0, rdat2);
        check_value("aux_rsp_o.dat", 64'(w_a), 64'(rdat2));
        read_word(make_adr(REGION_SRAM, 10'd251), rdat);
        check_value("mgmt_rsp_o.dat", 64'(w_b), 64'(rdat));
        end_test("arbitration");

        for (int h = 0; h < 2; h++) begin
            out_model[h] = $urandom;
            oeb_model[h] = $urandom;
            write_word(make_adr(REGION_GPIO, 10'(8 + h)), out_model[h]);
            write_word(make_adr(REGION_GPIO, 10'(10 + h)), oeb_model[h]);
        end
        check_value("io_out_o", 64'(mgmt_pins(out_model[0], out_model[1])), 64'(io_out));
        check_value("io_oeb_o", 64'(mgmt_pins(oeb_model[0], oeb_model[1])), 64'(io_oeb));
        for (int h = 0; h < 2; h++) begin
            read_word(make_adr(REGION_GPIO, 10'(8 + h)), rdat);
            check_value("gpio out register", 64'(out_model[h]), 64'(rdat));
            read_word(make_adr(REGION_GPIO, 10'(10 + h)), rdat);
            check_value("gpio oeb register", 64'(oeb_model[h]), 64'(rdat));
        end
        end_test("gpio management drive");

        own_model[0] = 32'h1111_1111;  // Pins 0..7 to team 0
        write_word(make_adr(REGION_GPIO, 10'd0), own_model[0]);
        write_word(make_adr(REGION_TEAM0, 10'd0), 32'h1);
        pins      = mgmt_pins(oeb_model[0], oeb_model[1]);
        pins[7:0] = 8'h00;
        check_value("io_oeb_o", 64'(pins), 64'(io_oeb));
        pins = mgmt_pins(out_model[0], out_model[1]);
        check_value("io_out_o[37:8]", 64'(pins[NUM_PINS-1:8]), 64'(io_out[NUM_PINS-1:8]));
        read_word(make_adr(REGION_GPIO, 10'd0), rdat);
        check_value("gpio owner register", 64'(own_model[0]), 64'(rdat));
        read_word(make_adr(REGION_TEAM0, 10'd1), w_a);
        read_word(make_adr(REGION_TEAM0, 10'd1), w_b);
        assert (w_b > w_a) else begin
            $display("MISMATCH time %0t signal team0 count expected above 0x%0h actual 0x%0h",
                     $time, w_a, w_b);
            err_cnt++;
        end
        write_word(make_adr(REGION_TEAM0, 10'd0), 32'h2);  // Clear, enable off
        read_word(make_adr(REGION_TEAM0, 10'd1), rdat);
        check_value("team0 count", 64'h0, 64'(rdat));
        // Stopped team still owns pins 0..7, zero count and no drive
        check_value("io_out_o[7:0]", 64'h0, 64'(io_out[7:0]));
        check_value("io_oeb_o[7:0]", 64'hFF, 64'(io_oeb[7:0]));
        wdat = $urandom;
        write_word(make_adr(REGION_TEAM0 + 4'd1, 10'd2), wdat);
        read_word(make_adr(REGION_TEAM0 + 4'd1, 10'd2), rdat);
        check_value("team1 scratch", 64'(wdat), 64'(rdat));
        end_test("team ownership and counting");

        read_word(make_adr(4'hF, 10'd0), rdat);
        check_value("mgmt_rsp_o.dat", 64'h0, 64'(rdat));
        read_word(make_adr(REGION_SRAM, 10'(idx[0])), rdat);
        check_value("mgmt_rsp_o.dat", 64'(sram_model[idx[0]]), 64'(rdat));
        end_test("unmapped region");

        $display("tests passed %0d failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: nebula_top.f
rtl/nebula_bus_pkg.sv
rtl/nebula_map_pkg.sv
rtl/wb_arbiter.sv
rtl/wb_decoder.sv
rtl/wb_sram.sv
rtl/gpio_control.sv
rtl/team_counter.sv
rtl/nebula_top.sv
verif/nebula_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f nebula_top.f --top-module nebula_tb -o nebula_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/nebula_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q '^TB PASSED$'; then
    exit 0
fi
exit 1
